// File: verilog/eth_rx_config.svh
`ifndef ETH_RX_CONFIG_SVH
`define ETH_RX_CONFIG_SVH

// start-of-frame delimiter as seen after nibble pairing
`define ETH_SFD 8'hD5

// station address, first byte on the wire in the top bits
`define ETH_MAC_ADDR 48'h02_45_54_48_52_58

// destination address bytes
`define MAC_ADDR_LEN 6

// first buffer byte of a frame
`define ETH_RX_BUFFER_START 11'd0

// buffer size in bytes
`define ETH_RX_BUF_DEPTH 2048

`endif

// File: verilog/eth_rx_pkg.sv
package eth_rx_pkg;

   typedef logic [7:0] byte_t;

   typedef logic [10:0] buf_addr_t;

   typedef logic [31:0] crc_t;

   // receive sequencer, two states per byte
   typedef enum logic [2:0] {
      st_hunt         = 3'd0,
      st_addr_setup   = 3'd1,
      st_mac_byte     = 3'd2,
      st_mac_check    = 3'd3,
      st_payload_byte = 3'd4,
      st_payload_next = 3'd5,
      st_frame_done   = 3'd6,
      st_discard      = 3'd7
   } rx_state_e;

endpackage

// File: verilog/eth_rx_wr_if.sv
`timescale 1ns/1ps

interface eth_rx_wr_if
   import eth_rx_pkg::*;
   ();

   buf_addr_t addr;
   byte_t     data;
   logic      wr;
   // high while the sequencer hunts for a frame
   logic      start;

   modport master (
      output addr,
      output data,
      output wr,
      output start
   );

   modport sink (
      input addr,
      input data,
      input wr
   );

   modport crc (
      input data,
      input wr,
      input start
   );

endinterface

// File: verilog/mii_nibble_assembler.sv
`timescale 1ns/1ps

module mii_nibble_assembler
   import eth_rx_pkg::*;
   (
   input  logic       RX_CLK,
   input  logic       rx_rst,
   input  logic       rx_dv,
   input  logic [3:0] rx_data,
   output byte_t      byte_now,
   output byte_t      byte_q
);

   // new nibble on top, previous nibble shifted down
   assign byte_now = {rx_data, byte_q[7:4]};

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         byte_q <= '0;
      end else if (rx_dv) begin
         byte_q <= byte_now;
      end
   end

endmodule

// File: verilog/eth_rx_sequencer.sv
`timescale 1ns/1ps

`include "eth_rx_config.svh"

module eth_rx_sequencer
   import eth_rx_pkg::*;
   (
   input  logic         RX_CLK,
   input  logic         rx_rst,
   input  logic         rx_dv,
   input  byte_t        byte_now,
   input  byte_t        byte_q,
   input  logic         rcv_ack,
   output logic         data_rcvd,
   output buf_addr_t    rx_len,
   eth_rx_wr_if.master  wr_bus
);

   localparam buf_addr_t LAST_MAC_ADDR =
      buf_addr_t'(`MAC_ADDR_LEN - 1) + `ETH_RX_BUFFER_START;

   rx_state_e    state;
   rx_state_e    state_nxt;
   buf_addr_t    addr;
   logic [47:0]  dest_mac;
   logic         wr;
   logic         start;

   assign wr_bus.addr  = addr;
   assign wr_bus.data  = byte_q;
   assign wr_bus.wr    = wr;
   assign wr_bus.start = start;

   always_comb begin
      state_nxt = state;
      case (state)
         st_hunt:
            if (rx_dv && byte_now == `ETH_SFD) begin
               state_nxt = st_addr_setup;
            end
         st_addr_setup:
            state_nxt = st_mac_byte;
         st_mac_byte:
            state_nxt = st_mac_check;
         st_mac_check:
            if (addr != LAST_MAC_ADDR) begin
               state_nxt = st_mac_byte;
            end else if (dest_mac != `ETH_MAC_ADDR) begin
               state_nxt = st_discard;
            end else begin
               state_nxt = st_payload_byte;
            end
         st_payload_byte:
            state_nxt = st_payload_next;
         st_payload_next:
            state_nxt = rx_dv ? st_payload_byte : st_frame_done;
         // frames arriving here are ignored until the ack
         st_frame_done:
            if (rcv_ack) begin
               state_nxt = st_hunt;
            end
         st_discard:
            if (!rx_dv) begin
               state_nxt = st_hunt;
            end
         default:
            state_nxt = st_hunt;
      endcase
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         state     <= st_hunt;
         addr      <= '0;
         dest_mac  <= '0;
         wr        <= 1'b0;
         start     <= 1'b0;
         data_rcvd <= 1'b0;
         rx_len    <= '0;
      end else begin
         state <= state_nxt;
         start <= (state_nxt == st_hunt);
         // byte_q holds the completed byte one cycle later
         wr    <= (state == st_mac_byte) || (state == st_payload_byte);
         case (state)
            st_addr_setup:
               addr <= `ETH_RX_BUFFER_START;
            st_mac_byte:
               dest_mac <= {dest_mac[39:0], byte_now};
            st_mac_check:
               addr <= addr + 1'b1;
            st_payload_next: begin
               addr <= addr + 1'b1;
               if (!rx_dv) begin
                  rx_len <= addr + 1'b1 - `ETH_RX_BUFFER_START;
               end
            end
            st_frame_done: begin
               data_rcvd <= !rcv_ack;
               if (rcv_ack) begin
                  addr <= '0;
               end
            end
            default: begin
            end
         endcase
      end
   end

endmodule

// File: verilog/eth_crc32.sv
`timescale 1ns/1ps

module eth_crc32
   import eth_rx_pkg::*;
   (
   input  logic      RX_CLK,
   input  logic      rx_rst,
   eth_rx_wr_if.crc  crc_bus,
   output crc_t      crc_value
);

   // 0x04C11DB7 bit-reversed
   localparam crc_t POLY_REFL = 32'hEDB88320;

   crc_t crc_q;
   crc_t crc_nxt;

   // eight bit-steps, lsb of the byte first
   always_comb begin
      crc_nxt = crc_q;
      for (int i = 0; i < 8; i++) begin
         if (crc_nxt[0] ^ crc_bus.data[i]) begin
            crc_nxt = (crc_nxt >> 1) ^ POLY_REFL;
         end else begin
            crc_nxt = crc_nxt >> 1;
         end
      end
   end

   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc_q <= '1;
      end else if (crc_bus.start) begin
         crc_q <= '1;
      end else if (crc_bus.wr) begin
         crc_q <= crc_nxt;
      end
   end

   // raw register, good frame leaves 0xDEBB20E3
   assign crc_value = crc_q;

endmodule

// File: verilog/eth_rx_buffer.sv
`timescale 1ns/1ps

`include "eth_rx_config.svh"

module eth_rx_buffer
   import eth_rx_pkg::*;
   (
   input  logic        RX_CLK,
   eth_rx_wr_if.sink   wr_bus,
   input  buf_addr_t   rd_addr,
   output byte_t       rd_data
);

   byte_t mem [`ETH_RX_BUF_DEPTH];

   always_ff @(posedge RX_CLK) begin
      if (wr_bus.wr) begin
         mem[wr_bus.addr] <= wr_bus.data;
      end
   end

   // registered read, block RAM style
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

endmodule

// File: verilog/eth_rx_top.sv
`timescale 1ns/1ps

`include "eth_rx_config.svh"

module eth_rx_top
   import eth_rx_pkg::*;
   (
   input  logic       RX_CLK,
   input  logic       rx_rst,
   input  logic       rx_dv,
   input  logic [3:0] rx_data,
   input  logic       rcv_ack,
   output logic       data_rcvd,
   output buf_addr_t  rx_len,
   output crc_t       crc_value,
   input  buf_addr_t  rd_addr,
   output byte_t      rd_data
);

   byte_t byte_now;
   byte_t byte_q;

   eth_rx_wr_if wr_bus ();

   mii_nibble_assembler u_assembler (
      .RX_CLK   (RX_CLK),
      .rx_rst   (rx_rst),
      .rx_dv    (rx_dv),
      .rx_data  (rx_data),
      .byte_now (byte_now),
      .byte_q   (byte_q)
   );

   eth_rx_sequencer u_sequencer (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .rx_dv     (rx_dv),
      .byte_now  (byte_now),
      .byte_q    (byte_q),
      .rcv_ack   (rcv_ack),
      .data_rcvd (data_rcvd),
      .rx_len    (rx_len),
      .wr_bus    (wr_bus.master)
   );

   eth_crc32 u_crc (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .crc_bus   (wr_bus.crc),
      .crc_value (crc_value)
   );

   eth_rx_buffer u_buffer (
      .RX_CLK  (RX_CLK),
      .wr_bus  (wr_bus.sink),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

endmodule

// File: verif/eth_rx_properties.sv
`timescale 1ns/1ps

module eth_rx_properties (
   input logic RX_CLK,
   input logic rx_rst,
   input logic rx_dv,
   input logic rcv_ack,
   input logic data_rcvd
);

   int assert_fails = 0;

   reset_clears_rcvd: assert property (@(posedge RX_CLK) rx_rst |-> !data_rcvd)
      else begin
         $error("data_rcvd high during reset");
         assert_fails++;
      end

   // level held until the host acknowledges
   rcvd_held_until_ack: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      data_rcvd && !rcv_ack |=> data_rcvd)
      else begin
         $error("data_rcvd fell without rcv_ack");
         assert_fails++;
      end

   rcvd_rises_when_idle: assert property (@(posedge RX_CLK) disable iff (rx_rst)
      $rose(data_rcvd) |-> !rx_dv)
      else begin
         $error("data_rcvd rose while rx_dv was high");
         assert_fails++;
      end

endmodule

bind eth_rx_top eth_rx_properties u_properties (
   .RX_CLK    (RX_CLK),
   .rx_rst    (rx_rst),
   .rx_dv     (rx_dv),
   .rcv_ack   (rcv_ack),
   .data_rcvd (data_rcvd)
);

// File: verif/eth_rx_tb.sv
`timescale 1ns/1ps

`include "eth_rx_config.svh"

module eth_rx_tb
   import eth_rx_pkg::*;
   ();

   localparam int BASE_PREAMBLE = 14;
   localparam int IDLE_CYCLES   = 12;
   localparam int RCVD_TIMEOUT  = 200;
   localparam int DROP_WINDOW   = 60;
   localparam int IDLE_TIMEOUT  = 50;
   localparam int NUM_ROWS      = 7;
   localparam byte_t SFD_BYTE   = `ETH_SFD;

   typedef struct {
      logic [47:0] dest;
      int          pay_len;
      int          pre_extra;
      bit          corrupt;
      bit          accept;
   } frame_row_t;

   logic       RX_CLK;
   logic       rx_rst;
   logic       rx_dv;
   logic [3:0] rx_data;
   logic       rcv_ack;
   logic       data_rcvd;
   buf_addr_t  rx_len;
   crc_t       crc_value;
   buf_addr_t  rd_addr;
   byte_t      rd_data;

   frame_row_t rows [NUM_ROWS];
   byte_t      frame_q [$];
   crc_t       exp_crc;
   integer     seed;
   int         err_count;
   int         rows_passed;
   int         rows_failed;

   eth_rx_top uut (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rx_rst),
      .rx_dv     (rx_dv),
      .rx_data   (rx_data),
      .rcv_ack   (rcv_ack),
      .data_rcvd (data_rcvd),
      .rx_len    (rx_len),
      .crc_value (crc_value),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #4 RX_CLK = ~RX_CLK;
   end

   // reflected CRC-32, one bit at a time
   function automatic crc_t crc_step(crc_t c, byte_t b);
      crc_t r;
      r = c;
      for (int i = 0; i < 8; i++) begin
         r = (r >> 1) ^ ({32{r[0] ^ b[i]}} & 32'hEDB88320);
      end
      return r;
   endfunction

   task automatic check_byte(byte_t got, byte_t exp, string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_len(buf_addr_t got, buf_addr_t exp, string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_crc(crc_t got, crc_t exp, string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic drive_cycle(logic dv, logic [3:0] nib);
      rx_dv   = dv;
      rx_data = nib;
      @(posedge RX_CLK);
      #1;
   endtask

   // destination, payload, then FCS low byte first
   task automatic build_frame(frame_row_t row);
      crc_t fcs;
      frame_q.delete();
      for (int i = 0; i < `MAC_ADDR_LEN; i++) begin
         frame_q.push_back(row.dest[47 - 8*i -: 8]);
      end
      for (int i = 0; i < row.pay_len; i++) begin
         frame_q.push_back(byte_t'($random(seed)));
      end
      fcs = '1;
      foreach (frame_q[i]) begin
         fcs = crc_step(fcs, frame_q[i]);
      end
      fcs = ~fcs;
      if (row.corrupt) begin
         fcs[13] = ~fcs[13];
      end
      for (int i = 0; i < 4; i++) begin
         frame_q.push_back(fcs[8*i +: 8]);
      end
      exp_crc = 32'hDEBB20E3;
      if (row.corrupt) begin
         exp_crc = '1;
         foreach (frame_q[i]) begin
            exp_crc = crc_step(exp_crc, frame_q[i]);
         end
      end
   endtask

   task automatic send_frame(frame_row_t row);
      for (int i = 0; i < BASE_PREAMBLE + row.pre_extra; i++) begin
         drive_cycle(1'b1, 4'h5);
      end
      drive_cycle(1'b1, SFD_BYTE[3:0]);
      drive_cycle(1'b1, SFD_BYTE[7:4]);
      foreach (frame_q[i]) begin
         drive_cycle(1'b1, frame_q[i][3:0]);
         drive_cycle(1'b1, frame_q[i][7:4]);
      end
      for (int i = 0; i < IDLE_CYCLES; i++) begin
         drive_cycle(1'b0, 4'h0);
      end
   endtask

   task automatic wait_rcvd(input int limit, output bit seen);
      int n;
      n = 0;
      while (!data_rcvd && n < limit) begin
         @(posedge RX_CLK);
         #1;
         n++;
      end
      seen = data_rcvd;
   endtask

   // crc back at all ones means the sequencer is hunting
   task automatic wait_idle();
      int n;
      n = 0;
      while (crc_value !== '1 && n < IDLE_TIMEOUT) begin
         @(posedge RX_CLK);
         #1;
         n++;
      end
      if (crc_value !== '1) begin
         $display("The receiver never returned to hunting before the next frame.");
         err_count++;
      end
   endtask

   task automatic acknowledge();
      rcv_ack = 1'b1;
      @(posedge RX_CLK);
      #1;
      rcv_ack = 1'b0;
      if (data_rcvd !== 1'b0) begin
         $display("ERROR %0t: data_rcvd stayed high after the acknowledge cycle", $time);
         err_count++;
      end
   endtask

   initial begin
      int errs_before;
      bit seen;
      rx_rst      = 1'b1;
      rx_dv       = 1'b0;
      rx_data     = 4'h0;
      rcv_ack     = 1'b0;
      rd_addr     = '0;
      seed        = 32'h4a27;
      err_count   = 0;
      rows_passed = 0;
      rows_failed = 0;
      rows[0] = '{`ETH_MAC_ADDR, 46, 0, 1'b0, 1'b1};
      rows[1] = '{`ETH_MAC_ADDR, 20, 3, 1'b1, 1'b1};
      rows[2] = '{48'h02_45_54_48_52_59, 30, 0, 1'b0, 1'b0};
      rows[3] = '{`ETH_MAC_ADDR, 10, 1, 1'b0, 1'b1};
      rows[4] = '{`ETH_MAC_ADDR, 64, 5, 1'b0, 1'b1};
      rows[5] = '{48'hFF_FF_FF_FF_FF_FF, 12, 2, 1'b0, 1'b0};
      rows[6] = '{`ETH_MAC_ADDR, 8, 0, 1'b1, 1'b1};
      repeat (3) @(posedge RX_CLK);
      #1;
      rx_rst = 1'b0;
      if (data_rcvd !== 1'b0) begin
         $display("ERROR %0t: data_rcvd was not low after reset", $time);
         err_count++;
      end
      check_len(rx_len, '0, "rx_len after reset");
      check_crc(crc_value, '1, "crc_value before first frame");
      for (int r = 0; r < NUM_ROWS; r++) begin
         errs_before = err_count;
         wait_idle();
         build_frame(rows[r]);
         send_frame(rows[r]);
         if (rows[r].accept) begin
            wait_rcvd(RCVD_TIMEOUT, seen);
            if (!seen) begin
               $display("Frame of row %0d was never signalled by data_rcvd.", r);
               err_count++;
            end else begin
               check_len(rx_len, buf_addr_t'(`MAC_ADDR_LEN + rows[r].pay_len + 4), "rx_len");
               check_crc(crc_value, exp_crc, "crc_value");
               foreach (frame_q[i]) begin
                  rd_addr = buf_addr_t'(i) + `ETH_RX_BUFFER_START;
                  @(posedge RX_CLK);
                  #1;
                  check_byte(rd_data, frame_q[i], $sformatf("buffer[%0d]", i));
               end
               acknowledge();
            end
         end else begin
            wait_rcvd(DROP_WINDOW, seen);
            if (seen) begin
               $display("data_rcvd rose for row %0d, a frame to a foreign address.", r);
               err_count++;
               acknowledge();
            end
         end
         if (err_count == errs_before) begin
            rows_passed++;
         end else begin
            rows_failed++;
         end
         $display("row %0d %s: %s", r, rows[r].accept ? "accepted" : "dropped",
                  (err_count == errs_before) ? "ok" : "mismatch");
      end
      err_count += uut.u_properties.assert_fails;
      $display("%0d rows ok, %0d rows wrong, %0d errors", rows_passed, rows_failed, err_count);
      if (rows_failed == 0 && err_count == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: src.f
+incdir+verilog
verilog/eth_rx_pkg.sv
verilog/eth_rx_wr_if.sv
verilog/mii_nibble_assembler.sv
verilog/eth_rx_sequencer.sv
verilog/eth_crc32.sv
verilog/eth_rx_buffer.sv
verilog/eth_rx_top.sv
verif/eth_rx_properties.sv
verif/eth_rx_tb.sv

// File: Bender.yml
package:
  name: eth_rx

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/eth_rx_pkg.sv
      - verilog/eth_rx_wr_if.sv
      - verilog/mii_nibble_assembler.sv
      - verilog/eth_rx_sequencer.sv
      - verilog/eth_crc32.sv
      - verilog/eth_rx_buffer.sv
      - verilog/eth_rx_top.sv
      - target: test
        files:
          - verif/eth_rx_properties.sv
          - verif/eth_rx_tb.sv
